// ==== Makefile ====
# Verilator build and run of the line doubler testbench

SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_linemult: compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_linemult

run: obj_dir/Vtb_linemult
	./obj_dir/Vtb_linemult | tee sim.log
	grep -q "^TEST RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
rtl/linemult_pkg.sv
rtl/line_buffer.sv
rtl/buffer_arbiter.sv
rtl/line_writer.sv
rtl/line_reader.sv
rtl/scanline_shader.sv
rtl/linemult_top.sv
test/tb_clock.sv
test/tb_linemult.sv

// ==== rtl/buffer_arbiter.sv ====
// arbiter for the shared line buffer, writes win and a colliding read waits one cycle
`timescale 1ns/100ps
`default_nettype none

module buffer_arbiter import linemult_pkg::*; (
  input  logic    VCLK_o,
  input  logic    nVRST_o,
  input  buf_wr_t wr_req_i,
  input  buf_rd_t rd_req_i,
  output logic    rd_valid_o,
  output rgb_t    rd_data_o
);

  buf_rd_t park_q;    // read held back by a write
  buf_rd_t rd_sel;
  logic    rd_grant;
  page_t   mem_page;
  addr_t   mem_addr;

  assign rd_sel   = park_q.valid ? park_q : rd_req_i;
  assign rd_grant = rd_sel.valid & ~wr_req_i.valid;

  // port address follows the winner
  assign mem_page = wr_req_i.valid ? wr_req_i.page : rd_sel.page;
  assign mem_addr = wr_req_i.valid ? wr_req_i.addr : rd_sel.addr;

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      park_q     <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      park_q <= '0;
      if (rd_sel.valid && wr_req_i.valid) park_q <= rd_sel;
      rd_valid_o <= rd_grant;  // memory data of this grant shows up next cycle
    end
  end

  line_buffer u_line_buffer (
    .VCLK_o    (VCLK_o),
    .we_i      (wr_req_i.valid),
    .re_i      (rd_grant),
    .page_i    (mem_page),
    .addr_i    (mem_addr),
    .wr_data_i (wr_req_i.rgb),
    .rd_data_o (rd_data_o)
  );

endmodule

`default_nettype wire

// ==== rtl/line_buffer.sv ====
// paged single-port pixel memory, one access per cycle with registered read data
`timescale 1ns/100ps
`default_nettype none

module line_buffer import linemult_pkg::*; (
  input  logic  VCLK_o,
  input  logic  we_i,
  input  logic  re_i,
  input  page_t page_i,
  input  addr_t addr_i,
  input  rgb_t  wr_data_i,
  output rgb_t  rd_data_o
);

  rgb_t mem [BUF_PAGES][PIXELS_MAX];

  // one shared port, write has priority
  always_ff @(posedge VCLK_o) begin
    if (we_i) begin
      mem[page_i][addr_i] <= wr_data_i;
    end else if (re_i) begin
      rd_data_o <= mem[page_i][addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/line_reader.sv ====
// line reader, replays every announced line twice at double rate with fresh output syncs
`timescale 1ns/100ps
`default_nettype none

module line_reader import linemult_pkg::*; (
  input  logic       VCLK_o,
  input  logic       nVRST_o,
  input  line_info_t line_i,
  output buf_rd_t    rd_req_o,
  input  logic       rd_valid_i,
  input  rgb_t       rd_data_i,
  output px_stream_t px_o
);

  page_t             rd_page;
  addr_t             len;
  logic              run;
  logic              replay;
  logic [ADDR_W:0]   cyc;       // cycle within one replay, two per pixel
  logic [VCNT_W-1:0] vcnt;      // output lines since frame start, saturating
  logic [VCNT_W-1:0] vcnt_inc;
  logic              last;
  px_stream_t        ctl0;      // control of the current cycle, no color
  px_stream_t        ctl_d1;
  px_stream_t        ctl_d2;
  logic [1:0]        first_d;   // first cycle of a pixel, delayed
  rgb_t              data_q;
  rgb_t              rgb_new;

  assign last     = cyc == ({len, 1'b0} - 1'b1);
  assign vcnt_inc = (vcnt == VCNT_W'(VS_LINES_OUT)) ? vcnt : vcnt + 1'b1;

  // one read on the first cycle of each output pixel
  assign rd_req_o = '{valid: run & ~cyc[0], page: rd_page, addr: cyc[ADDR_W:1]};

  always_comb begin
    ctl0             = '0;
    ctl0.active      = run;
    ctl0.replay      = replay;
    ctl0.sync.nhsync = ~(run & (cyc < HS_WIDTH_OUT));
    ctl0.sync.nvsync = ~(run & (vcnt < VS_LINES_OUT));
  end

  ////////////////////////////////////////
  // replay control
  ////////////////////////////////////////
  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      rd_page <= '0;
      len     <= '0;
      run     <= 1'b0;
      replay  <= 1'b0;
      cyc     <= '0;
      vcnt    <= VCNT_W'(VS_LINES_OUT);  // vsync inactive until a frame starts
    end else if (line_i.strobe) begin
      rd_page <= line_i.page;
      len     <= line_i.len;
      run     <= line_i.len != '0;
      replay  <= 1'b0;
      cyc     <= '0;
      vcnt    <= line_i.frame_start ? '0 : vcnt_inc;
    end else if (run) begin
      if (last) begin
        cyc <= '0;
        if (replay) begin
          run <= 1'b0;  // both copies done, wait for next line
        end else begin
          replay <= 1'b1;
          vcnt   <= vcnt_inc;
        end
      end else begin
        cyc <= cyc + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // fixed three cycle output stage
  ////////////////////////////////////////
  // data comes back after one or two cycles, take it straight or from the latch
  assign rgb_new = rd_valid_i ? rd_data_i : data_q;

  always_ff @(posedge VCLK_o) begin
    if (rd_valid_i) data_q <= rd_data_i;
  end

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      ctl_d1  <= '0;
      ctl_d2  <= '0;
      first_d <= '0;
      px_o    <= '0;
    end else begin
      ctl_d1  <= ctl0;
      ctl_d2  <= ctl_d1;
      first_d <= {first_d[0], run & ~cyc[0]};
      px_o    <= ctl_d2;  // rgb zero while inactive
      if (ctl_d2.active) px_o.rgb <= first_d[1] ? rgb_new : px_o.rgb;  // hold for 2nd cycle
    end
  end

endmodule

`default_nettype wire

// ==== rtl/line_writer.sv ====
// line writer, stores each input line into the next buffer page and announces its length
`timescale 1ns/100ps
`default_nettype none

module line_writer import linemult_pkg::*; (
  input  logic       VCLK_o,
  input  logic       nVRST_o,
  input  logic       pix_strobe_i,
  input  vdata_in_t  vdata_i,
  output buf_wr_t    wr_req_o,
  output line_info_t line_o
);

  sync_t sync_prev;   // sync bits of the previous pixel
  page_t wr_page;
  addr_t pix_cnt;
  logic  frame_pend;  // next announced line starts a frame
  logic  hs_fall;
  logic  vs_fall;
  page_t page_nxt;

  assign hs_fall = sync_prev.nhsync & ~vdata_i.sync.nhsync;
  assign vs_fall = sync_prev.nvsync & ~vdata_i.sync.nvsync;

  // new frame restarts at page 0
  assign page_nxt = (vs_fall || wr_page == page_t'(BUF_PAGES - 1)) ? '0 : page_t'(wr_page + 1'b1);

  ////////////////////////////////////////
  // edge detection, counting, writes
  ////////////////////////////////////////
  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      sync_prev  <= '0;  // no edge seen right after reset
      wr_page    <= '0;
      pix_cnt    <= '0;
      frame_pend <= 1'b0;
      wr_req_o   <= '0;
      line_o     <= '0;
    end else begin
      wr_req_o.valid <= 1'b0;
      line_o.strobe  <= 1'b0;

      if (pix_strobe_i) begin
        sync_prev    <= vdata_i.sync;
        wr_req_o.rgb <= vdata_i.rgb;

        if (hs_fall) begin
          // close the running line
          line_o.strobe      <= 1'b1;
          line_o.frame_start <= frame_pend;
          line_o.page        <= wr_page;
          line_o.len         <= pix_cnt;
          frame_pend         <= vs_fall;
          wr_page            <= page_nxt;

          // this pixel opens the new line
          wr_req_o.valid <= 1'b1;
          wr_req_o.page  <= page_nxt;
          wr_req_o.addr  <= '0;
          pix_cnt        <= addr_t'(1);
        end else if (pix_cnt < PIXELS_MAX) begin
          wr_req_o.valid <= 1'b1;
          wr_req_o.page  <= wr_page;
          wr_req_o.addr  <= pix_cnt;
          pix_cnt        <= pix_cnt + 1'b1;
        end  // else clamp, drop the rest of the line
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/linemult_pkg.sv ====
// shared sizes and packed bus types of the line doubler, imported by every rtl module
`default_nettype none

package linemult_pkg;

  ////////////////////////////////////////
  // sizes and timing
  ////////////////////////////////////////
  localparam int COLOR_W      = 7;     // input color width
  localparam int COLOR_OUT_W  = 8;     // output color width
  localparam int BUF_PAGES    = 4;     // line pages in the buffer
  localparam int PIXELS_MAX   = 400;   // longer lines are clamped
  localparam int HS_WIDTH_OUT = 16;    // output hsync pulse in cycles
  localparam int VS_LINES_OUT = 6;     // output lines with vsync low

  localparam int PAGE_W = $clog2(BUF_PAGES);
  localparam int ADDR_W = $clog2(PIXELS_MAX);
  localparam int VCNT_W = $clog2(VS_LINES_OUT + 1);  // counts up to VS_LINES_OUT

  ////////////////////////////////////////
  // basic types
  ////////////////////////////////////////
  typedef logic [COLOR_W-1:0]     color_t;
  typedef logic [COLOR_OUT_W-1:0] color_out_t;
  typedef logic [PAGE_W-1:0]      page_t;
  typedef logic [ADDR_W-1:0]      addr_t;

  typedef struct packed {
    logic nvsync;  // active low
    logic nhsync;  // active low
  } sync_t;

  typedef struct packed {color_t r; color_t g; color_t b;} rgb_t;
  typedef struct packed {color_out_t r; color_out_t g; color_out_t b;} rgb_out_t;

  typedef struct packed {sync_t sync; rgb_t rgb;} vdata_in_t;
  typedef struct packed {sync_t sync; rgb_out_t rgb;} vdata_out_t;

  ////////////////////////////////////////
  // configuration and internal buses
  ////////////////////////////////////////
  typedef struct packed {
    logic       enable;  // line doubling on
    logic       sl_en;   // scanlines on
    logic       sl_id;   // replay that gets shaded
    logic [7:0] sl_str;  // shading strength
  } lm_cfg_t;

  typedef struct packed {
    logic  strobe;       // one cycle per finished line
    logic  frame_start;  // first line of a frame
    page_t page;
    addr_t len;          // stored pixels
  } line_info_t;

  typedef struct packed {logic valid; page_t page; addr_t addr; rgb_t rgb;} buf_wr_t;
  typedef struct packed {logic valid; page_t page; addr_t addr;} buf_rd_t;

  typedef struct packed {
    logic  active;
    logic  replay;  // 0 for the first copy of a line, 1 for the second
    sync_t sync;
    rgb_t  rgb;
  } px_stream_t;

endpackage

`default_nettype wire

// ==== rtl/linemult_top.sv ====
// top of the line doubler, ties writer, reader, buffer arbiter and shader together
`timescale 1ns/100ps
`default_nettype none

module linemult_top import linemult_pkg::*; (
  input  logic       VCLK_o,
  input  logic       nVRST_o,
  input  logic       pix_strobe_i,
  input  vdata_in_t  vdata_i,
  input  lm_cfg_t    cfg_i,
  output vdata_out_t vdata_o
);

  buf_wr_t    wr_req;
  buf_rd_t    rd_req;
  logic       rd_valid;
  rgb_t       rd_data;
  line_info_t line_info;
  px_stream_t px;

  line_writer u_line_writer (
    .VCLK_o       (VCLK_o),
    .nVRST_o      (nVRST_o),
    .pix_strobe_i (pix_strobe_i),
    .vdata_i      (vdata_i),
    .wr_req_o     (wr_req),
    .line_o       (line_info)
  );

  line_reader u_line_reader (
    .VCLK_o     (VCLK_o),
    .nVRST_o    (nVRST_o),
    .line_i     (line_info),
    .rd_req_o   (rd_req),
    .rd_valid_i (rd_valid),
    .rd_data_i  (rd_data),
    .px_o       (px)
  );

  buffer_arbiter u_buffer_arbiter (
    .VCLK_o     (VCLK_o),
    .nVRST_o    (nVRST_o),
    .wr_req_i   (wr_req),
    .rd_req_i   (rd_req),
    .rd_valid_o (rd_valid),
    .rd_data_o  (rd_data)
  );

  scanline_shader u_scanline_shader (
    .VCLK_o  (VCLK_o),
    .nVRST_o (nVRST_o),
    .cfg_i   (cfg_i),
    .px_i    (px),
    .vdata_i (vdata_i),
    .vdata_o (vdata_o)
  );

endmodule

`default_nettype wire

// ==== rtl/scanline_shader.sv ====
// output stage, shades one replay as scanline, widens colors and handles the bypass
`timescale 1ns/100ps
`default_nettype none

module scanline_shader import linemult_pkg::*; (
  input  logic       VCLK_o,
  input  logic       nVRST_o,
  input  lm_cfg_t    cfg_i,
  input  px_stream_t px_i,
  input  vdata_in_t  vdata_i,
  output vdata_out_t vdata_o
);

  sync_t sync_q;
  rgb_t  rgb_q;
  logic  sl_q;    // pixel belongs to the shaded replay

  // repeat the msb so full scale stays full scale
  function automatic rgb_out_t widen_rgb(rgb_t c);
    return '{r: {c.r, c.r[COLOR_W-1]}, g: {c.g, c.g[COLOR_W-1]}, b: {c.b, c.b[COLOR_W-1]}};
  endfunction

  // c * (255 - str) >> 7
  function automatic color_out_t shade(color_t c, logic [7:0] str);
    logic [COLOR_W+7:0] prod;
    prod = c * (8'd255 - str);
    return prod[COLOR_W+7:7];
  endfunction

  function automatic rgb_out_t shade_rgb(rgb_t c, logic [7:0] str);
    return '{r: shade(c.r, str), g: shade(c.g, str), b: shade(c.b, str)};
  endfunction

  ////////////////////////////////////////
  // stage 1, scanline decision
  ////////////////////////////////////////
  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      sync_q <= '0;
      rgb_q  <= '0;
      sl_q   <= 1'b0;
    end else begin
      sync_q <= px_i.sync;
      rgb_q  <= px_i.rgb;
      sl_q   <= cfg_i.sl_en & (px_i.replay == cfg_i.sl_id);
    end
  end

  ////////////////////////////////////////
  // stage 2, output register
  ////////////////////////////////////////
  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      vdata_o <= '0;
    end else if (!cfg_i.enable) begin
      vdata_o <= '{sync: vdata_i.sync, rgb: widen_rgb(vdata_i.rgb)};  // plain pass through
    end else if (sl_q) begin
      vdata_o <= '{sync: sync_q, rgb: shade_rgb(rgb_q, cfg_i.sl_str)};
    end else begin
      vdata_o <= '{sync: sync_q, rgb: widen_rgb(rgb_q)};
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
// testbench clock and reset source, 20 ns clock with reset held low for the first 4 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
  output logic VCLK_o,
  output logic nVRST_o
);

  localparam int RESET_CYCLES = 4;

  initial begin
    VCLK_o = 1'b0;
    forever #10 VCLK_o = ~VCLK_o;  // 20 ns period
  end

  // reset drops just after time zero so the async reset sees a real edge
  initial begin
    nVRST_o = 1'b1;
    #1;
    nVRST_o = 1'b0;
    repeat (RESET_CYCLES) @(negedge VCLK_o);
    nVRST_o = 1'b1;  // released on a falling edge
  end

endmodule

`default_nettype wire

// ==== test/tb_linemult.sv ====
// line doubler testbench that sends framed random pixel lines and checks the output stream
`timescale 1ns/100ps
`default_nettype none

module tb_linemult import linemult_pkg::*; ();

  localparam int LINE_PX     = 32;  // input pixels per line with blanking
  localparam int BLANK_PX    = 4;
  localparam int ACTIVE_PX   = LINE_PX - BLANK_PX;
  localparam int FRAME_LINES = 12;
  localparam int TOTAL_LINES = 5 * FRAME_LINES;
  localparam int ON_LINES    = 4 * FRAME_LINES;  // lines sent with doubling on
  localparam int CYCLE_LIMIT = 2 * (TOTAL_LINES * LINE_PX * 4 + 8);
  localparam int T_RESET     = 0;
  localparam int T_DOUBLE    = 1;
  localparam int T_SL0       = 2;
  localparam int T_SL1       = 3;
  localparam int T_SYNC      = 4;
  localparam int T_BYPASS    = 5;

  logic       VCLK_o;
  logic       nVRST_o;
  logic       pix_strobe;
  vdata_in_t  vdata_in;
  lm_cfg_t    cfg;
  vdata_out_t vdata_out;
  integer     seed = 32'hb011b92e;
  rgb_t       line_px [TOTAL_LINES][ACTIVE_PX];  // active pixels as sent
  int         errors [6] = '{default: 0};
  int         checked [6] = '{default: 0};
  int         cycles = 0;
  int         sent_lines = 0;
  int         rel_cnt = 0;
  logic       byp_armed = 1'b0;
  vdata_out_t byp_exp;
  logic       hs_prev = 1'b0;
  logic       hs_seen = 1'b0;
  int         hs_len = 0;
  int         out_line = -1;  // output lines counted by nhsync falls
  lm_cfg_t    line_cfg;
  rgb_out_t   run_px [$];     // run-collapsed nonzero colors of the current line
  rgb_out_t   last_px = '0;
  logic       vs_prev = 1'b1;
  int         vs_run = 0;
  int         vs_start = -1;
  int         vs_runs = 0;

  tb_clock u_clock (
    .VCLK_o  (VCLK_o),
    .nVRST_o (nVRST_o)
  );

  linemult_top dut_i (
    .VCLK_o       (VCLK_o),
    .nVRST_o      (nVRST_o),
    .pix_strobe_i (pix_strobe),
    .vdata_i      (vdata_in),
    .cfg_i        (cfg),
    .vdata_o      (vdata_out)
  );

  function automatic string test_name(input int t);
    case (t)
      T_RESET:  return "reset";
      T_DOUBLE: return "doubling";
      T_SL0:    return "scanline_id0";
      T_SL1:    return "scanline_id1";
      T_SYNC:   return "syncs";
      default:  return "bypass";
    endcase
  endfunction

  // 7 to 8 bits by repeating the top bit
  function automatic rgb_out_t widen(input rgb_t c);
    rgb_out_t o;
    o.r = {c.r, c.r[COLOR_W-1]};
    o.g = {c.g, c.g[COLOR_W-1]};
    o.b = {c.b, c.b[COLOR_W-1]};
    return o;
  endfunction

  // c * (255 - str) >> 7 on every channel
  function automatic rgb_out_t darken(input rgb_t c, input logic [7:0] str);
    rgb_out_t o;
    o.r = color_out_t'((int'(c.r) * (255 - int'(str))) >> 7);
    o.g = color_out_t'((int'(c.g) * (255 - int'(str))) >> 7);
    o.b = color_out_t'((int'(c.b) * (255 - int'(str))) >> 7);
    return o;
  endfunction

  task automatic note_mismatch(input int t, input string what, input longint e, input longint a);
    $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h", test_name(t), what, e, a);
    errors[t]++;
  endtask

  task automatic report_test(input int t);
    if (checked[t] == 0) begin
      $display("ERROR %s: no output was ever checked", test_name(t));
      errors[t]++;
    end
    $display("test %s done: %0d checks, %0d errors", test_name(t), checked[t], errors[t]);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  task automatic send_line(input int ln, input lm_cfg_t c);
    rgb_t prev;
    rgb_t px;
    prev = '0;
    for (int p = 0; p < LINE_PX; p++) begin
      px = '0;
      if (p >= BLANK_PX) begin
        px = rgb_t'($random(seed));
        while (px == '0 || px == prev) px = rgb_t'($random(seed));  // neighbors differ
        line_px[ln][p - BLANK_PX] = px;
      end
      prev = px;
      for (int k = 0; k < 4; k++) begin
        @(negedge VCLK_o);
        cfg                  = c;
        pix_strobe           = (k == 0);
        vdata_in.sync.nvsync = (ln % FRAME_LINES) != 0;  // low on the first line of a frame
        vdata_in.sync.nhsync = p >= 2;
        vdata_in.rgb         = px;
      end
    end
  endtask

  task automatic run_lines(input int n, input lm_cfg_t c);
    for (int i = 0; i < n; i++) begin
      send_line(sent_lines, c);
      sent_lines++;
    end
  endtask

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  // output line j replays copy j%2 of input line j/2
  task automatic check_line();
    logic     shaded;
    logic     bad;
    int       ln;
    int       t;
    rgb_out_t e;
    ln = out_line / 2;
    if (line_cfg != cfg || ln >= sent_lines) return;  // config moved during the line
    shaded = line_cfg.sl_en && ((out_line % 2) == int'(line_cfg.sl_id));
    t = !line_cfg.sl_en ? T_DOUBLE : (line_cfg.sl_id ? T_SL1 : T_SL0);
    bad = 1'b0;
    checked[t]++;
    assert (run_px.size() == ACTIVE_PX) else begin
      note_mismatch(t, $sformatf("line %0d pixel count", out_line), ACTIVE_PX, run_px.size());
      bad = 1'b1;
    end
    for (int i = 0; i < ACTIVE_PX && !bad; i++) begin
      e = shaded ? darken(line_px[ln][i], line_cfg.sl_str) : widen(line_px[ln][i]);
      assert (run_px[i] == e) else begin
        note_mismatch(t, $sformatf("line %0d pixel %0d", out_line, i), e, run_px[i]);
        bad = 1'b1;
      end
    end
  endtask

  task automatic check_vsync(input logic nv);
    if (!nv && vs_prev) begin
      if (vs_start >= 0) begin
        checked[T_SYNC]++;
        assert (out_line - vs_start == 2 * FRAME_LINES)
          else note_mismatch(T_SYNC, "lines per frame", 2 * FRAME_LINES, out_line - vs_start);
      end
      vs_start = out_line;
      vs_run   = 0;
    end
    if (!nv) vs_run++;
    if (nv && !vs_prev) begin
      vs_runs++;
      checked[T_SYNC]++;
      assert (vs_run == VS_LINES_OUT)
        else note_mismatch(T_SYNC, "vsync lines", VS_LINES_OUT, vs_run);
    end
    vs_prev = nv;
  endtask

  // reset and bypass checks on outputs sampled before this edge updates them
  always @(posedge VCLK_o) begin
    if (!nVRST_o || rel_cnt < 2) begin
      checked[T_RESET]++;
      assert (vdata_out == '0) else note_mismatch(T_RESET, "vdata_o", 0, vdata_out);
    end
    if (nVRST_o && rel_cnt < 2) rel_cnt++;
    if (nVRST_o && byp_armed) begin
      checked[T_BYPASS]++;
      assert (vdata_out == byp_exp) else note_mismatch(T_BYPASS, "vdata_o", byp_exp, vdata_out);
    end
    byp_armed    = nVRST_o && !cfg.enable;
    byp_exp.sync = vdata_in.sync;
    byp_exp.rgb  = widen(vdata_in.rgb);
  end

  // doubled stream split into lines at nhsync falls
  always @(posedge VCLK_o) begin
    if (nVRST_o && cfg.enable) begin
      if (hs_prev && !vdata_out.sync.nhsync) begin
        if (out_line >= 0) check_line();
        out_line++;
        line_cfg = cfg;
        run_px.delete();
        last_px  = '0;
        hs_len   = 0;
        hs_seen  = 1'b1;
        check_vsync(vdata_out.sync.nvsync);
      end
      if (!vdata_out.sync.nhsync) hs_len++;
      if (!hs_prev && vdata_out.sync.nhsync && hs_seen) begin
        checked[T_SYNC]++;
        assert (hs_len == HS_WIDTH_OUT)
          else note_mismatch(T_SYNC, "hsync width", HS_WIDTH_OUT, hs_len);
      end
      if (vdata_out.rgb != last_px && vdata_out.rgb != '0) run_px.push_back(vdata_out.rgb);
      last_px = vdata_out.rgb;
    end
    hs_prev = vdata_out.sync.nhsync;
  end

  always @(posedge VCLK_o) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the stimulus never finished", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin
    lm_cfg_t c;
    int      total;
    pix_strobe = 1'b0;
    vdata_in   = '0;
    cfg        = '0;
    cfg.enable = 1'b1;
    c          = cfg;
    // whole reset pulse, assert then release
    @(negedge nVRST_o);
    @(posedge nVRST_o);
    repeat (2) @(negedge VCLK_o);
    report_test(T_RESET);

    run_lines(2 * FRAME_LINES, c);
    report_test(T_DOUBLE);
    c.sl_en  = 1'b1;
    c.sl_id  = 1'b0;
    c.sl_str = {1'b0, 7'($random(seed))};
    run_lines(FRAME_LINES, c);
    report_test(T_SL0);
    c.sl_id  = 1'b1;
    c.sl_str = {1'b0, 7'($random(seed))};
    run_lines(FRAME_LINES, c);
    report_test(T_SL1);
    // the first frame after reset carries no frame start
    assert (vs_runs == ON_LINES / FRAME_LINES - 1)
      else note_mismatch(T_SYNC, "vsync frames", ON_LINES / FRAME_LINES - 1, vs_runs);
    report_test(T_SYNC);

    c.enable = 1'b0;
    run_lines(FRAME_LINES, c);
    report_test(T_BYPASS);

    total = 0;
    foreach (errors[i]) total += errors[i];
    $display("summary: %0d tests, %0d errors", 6, total);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
